// File: project.f
swarm_task_pkg.sv
tsb_pkg.sv
tsb_dest_map.sv
tsb_entry_table.sv
tsb_resp_return.sv
tsb_lvt_scan.sv
tsb_top.sv
tb_tsb.sv

// File: swarm_task_pkg.sv
`default_nettype none

package swarm_task_pkg;

   localparam int N_TILES = 16;

   // Lower value is older
   typedef logic [31:0] ts_t;

   localparam ts_t TS_NONE = '1; // No valid timestamp

   typedef logic [3:0] tile_id_t;
   typedef logic [7:0] epoch_t;
   typedef logic [6:0] tq_slot_t;
   typedef logic [4:0] cq_slice_slot_t;
   typedef logic [1:0] child_id_t;

   // Hint bits 7:4 select the destination tile
   typedef struct packed {
      ts_t         ts;
      logic [31:0] hint;
      logic [3:0]  fn_id;
      logic [63:0] args;
   } task_t;

endpackage

`default_nettype wire

// File: tb_tsb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tsb;

   localparam int MAX_CYCLES = 3000; // About 1800 cycles of stimulus plus margin

   logic                            clk;
   logic                            rstn;
   logic                            s_wvalid;
   logic                            s_wready;
   tsb_pkg::tsb_child_req_t         s_wdata;
   logic                            retry_valid;
   logic                            retry_ready;
   tsb_pkg::tsb_entry_id_t          retry_tsb_id;
   logic                            retry_abort;
   logic                            retry_tied;
   logic                            task_enq_valid;
   logic                            task_enq_ready;
   tsb_pkg::tsb_enq_t               task_enq;
   logic                            task_resp_valid;
   logic                            task_resp_ready;
   tsb_pkg::tsb_resp_in_t           task_resp;
   logic                            m_resp_valid;
   logic                            m_resp_ready;
   tsb_pkg::tsb_resp_out_t          m_resp;
   tsb_pkg::tsb_reg_req_t           reg_req;
   tsb_pkg::tsb_reg_rsp_t           reg_rsp;
   logic                            s_only_untied;
   swarm_task_pkg::ts_t             lvt;
   logic                            empty;

   // Reference model of the buffer
   logic [tsb_pkg::TSB_SIZE-1:0]    mdl_valid;
   swarm_task_pkg::task_t           mdl_task  [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::tile_id_t        mdl_tile  [tsb_pkg::TSB_SIZE];
   logic                            mdl_tied  [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::cq_slice_slot_t  mdl_cq    [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::child_id_t       mdl_child [tsb_pkg::TSB_SIZE];
   int                              log_tiles;
   logic                            exp_enq_valid;
   tsb_pkg::tsb_enq_t               exp_enq;
   logic                            exp_m_valid;
   tsb_pkg::tsb_resp_out_t          exp_m_resp;
   logic                            exp_rvalid;
   logic [31:0]                     exp_rdata;
   swarm_task_pkg::ts_t             exp_lvt;
   int                              stable;   // Cycles since the table last changed
   logic                            enq_open;
   logic                            mdl_full;
   int                              value_errs = 0;
   int                              other_errs = 0;

   tsb_top dut_i (
      .clk             (clk),
      .rstn            (rstn),
      .s_wvalid        (s_wvalid),
      .s_wready        (s_wready),
      .s_wdata         (s_wdata),
      .retry_valid     (retry_valid),
      .retry_ready     (retry_ready),
      .retry_tsb_id    (retry_tsb_id),
      .retry_abort     (retry_abort),
      .retry_tied      (retry_tied),
      .task_enq_valid  (task_enq_valid),
      .task_enq_ready  (task_enq_ready),
      .task_enq        (task_enq),
      .task_resp_valid (task_resp_valid),
      .task_resp_ready (task_resp_ready),
      .task_resp       (task_resp),
      .m_resp_valid    (m_resp_valid),
      .m_resp_ready    (m_resp_ready),
      .m_resp          (m_resp),
      .reg_req         (reg_req),
      .reg_rsp         (reg_rsp),
      .s_only_untied   (s_only_untied),
      .lvt             (lvt),
      .empty           (empty)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic tsb_pkg::tsb_entry_id_t lowest_free(input logic [15:0] v);
      int k;
      k = 0;
      while (k < 15 && v[k]) k++;
      return tsb_pkg::tsb_entry_id_t'(k);
   endfunction

   // Takes n hint bits from bit 4 upward
   function automatic swarm_task_pkg::tile_id_t tile_for_hint(input logic [31:0] hint,
                                                              input int n);
      int mask;
      mask = (1 << n) - 1;
      return swarm_task_pkg::tile_id_t'(hint[7:4] & mask);
   endfunction

   task automatic report_mismatch(input string name, input logic [159:0] got,
                                  input logic [159:0] exp);
      value_errs++;
      $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
   endtask

   assign enq_open = !exp_enq_valid || task_enq_ready;
   assign mdl_full = &mdl_valid;

   always_comb begin
      exp_lvt = swarm_task_pkg::TS_NONE;
      for (int k = 0; k < tsb_pkg::TSB_SIZE; k++) begin
         if (mdl_valid[k] && mdl_task[k].ts < exp_lvt) exp_lvt = mdl_task[k].ts;
      end
   end

   always @(posedge clk) begin
      logic                   new_go;
      logic                   retry_go;
      logic                   rsp_go;
      tsb_pkg::tsb_entry_id_t fid;
      tsb_pkg::tsb_entry_id_t rid;
      if (!rstn) begin
         mdl_valid     <= '0;
         exp_enq_valid <= 1'b0;
         exp_m_valid   <= 1'b0;
         exp_rvalid    <= 1'b0;
         log_tiles     <= 4;
         stable        <= 0;
      end else begin
         new_go   = s_wvalid && enq_open && !mdl_full;
         retry_go = retry_valid && enq_open && (!s_wvalid || mdl_full);
         rsp_go   = task_resp_valid && !exp_m_valid;
         fid      = lowest_free(mdl_valid);
         rid      = task_resp.tsb_id;
         if (reg_req.wvalid && reg_req.waddr == tsb_pkg::TSB_LOG_N_TILES) begin
            log_tiles <= (reg_req.wdata > 32'd4) ? 4 : int'(reg_req.wdata);
         end
         if (new_go) begin
            exp_enq_valid  <= 1'b1;
            exp_enq        <= '{task_data: s_wdata.task_data, tied: s_wdata.tied,
                                dest_tile: tile_for_hint(s_wdata.task_data.hint, log_tiles),
                                tsb_id: fid};
            mdl_task[fid]  <= s_wdata.task_data;
            mdl_tile[fid]  <= tile_for_hint(s_wdata.task_data.hint, log_tiles);
            mdl_tied[fid]  <= s_wdata.tied;
            mdl_cq[fid]    <= s_wdata.cq_slot;
            mdl_child[fid] <= s_wdata.child_id;
         end else if (retry_go && !retry_abort) begin
            exp_enq_valid <= 1'b1;
            exp_enq       <= '{task_data: mdl_task[retry_tsb_id], tied: retry_tied,
                               dest_tile: mdl_tile[retry_tsb_id], tsb_id: retry_tsb_id};
            mdl_tied[retry_tsb_id] <= retry_tied;
         end else if (task_enq_ready) begin
            exp_enq_valid <= 1'b0;
         end
         if (rsp_go && mdl_tied[rid]) begin
            exp_m_valid <= 1'b1;
            exp_m_resp  <= '{ack: task_resp.ack, tsb_slot: rid, epoch: task_resp.epoch,
                             tq_slot: task_resp.tq_slot, tile_id: mdl_tile[rid],
                             cq_slot: mdl_cq[rid], child_id: mdl_child[rid]};
         end else if (m_resp_ready) begin
            exp_m_valid <= 1'b0;
         end
         // A new allocation wins over a free of the same bit
         if (retry_go && retry_abort) mdl_valid[retry_tsb_id] <= 1'b0;
         if (rsp_go && task_resp.ack) mdl_valid[rid] <= 1'b0;
         if (new_go) mdl_valid[fid] <= 1'b1;
         if (new_go || (retry_go && retry_abort) || (rsp_go && task_resp.ack)) begin
            stable <= 0;
         end else if (stable < 1000) begin
            stable <= stable + 1;
         end
         exp_rvalid <= reg_req.arvalid;
         if (reg_req.arvalid) begin
            exp_rdata <= (reg_req.araddr == tsb_pkg::TSB_ENTRY_VALID) ? 32'(mdl_valid) : '0;
         end
      end
   end

   a_enq_valid: assert property (@(posedge clk) disable iff (!rstn)
      task_enq_valid == exp_enq_valid)
      else report_mismatch("task_enq_valid", $sampled(task_enq_valid), $sampled(exp_enq_valid));
   a_enq_data: assert property (@(posedge clk) disable iff (!rstn)
      !exp_enq_valid || task_enq === exp_enq)
      else report_mismatch("task_enq", $sampled(task_enq), $sampled(exp_enq));
   a_wready: assert property (@(posedge clk) disable iff (!rstn)
      s_wready == (enq_open && !mdl_full))
      else report_mismatch("s_wready", $sampled(s_wready), $sampled(enq_open && !mdl_full));
   a_retry_ready: assert property (@(posedge clk) disable iff (!rstn)
      retry_ready == (enq_open && (!s_wvalid || mdl_full)))
      else report_mismatch("retry_ready", $sampled(retry_ready),
                           $sampled(enq_open && (!s_wvalid || mdl_full)));
   a_m_valid: assert property (@(posedge clk) disable iff (!rstn)
      m_resp_valid == exp_m_valid)
      else report_mismatch("m_resp_valid", $sampled(m_resp_valid), $sampled(exp_m_valid));
   a_m_data: assert property (@(posedge clk) disable iff (!rstn)
      !exp_m_valid || m_resp === exp_m_resp)
      else report_mismatch("m_resp", $sampled(m_resp), $sampled(exp_m_resp));
   a_resp_ready: assert property (@(posedge clk) disable iff (!rstn)
      task_resp_ready == !exp_m_valid)
      else report_mismatch("task_resp_ready", $sampled(task_resp_ready),
                           $sampled(!exp_m_valid));
   a_untied: assert property (@(posedge clk) disable iff (!rstn)
      s_only_untied == ($countones(mdl_valid) > tsb_pkg::ONLY_UNTIED_LIMIT))
      else report_mismatch("s_only_untied", $sampled(s_only_untied),
                           $sampled($countones(mdl_valid) > tsb_pkg::ONLY_UNTIED_LIMIT));
   a_empty: assert property (@(posedge clk) disable iff (!rstn)
      empty == (mdl_valid == '0))
      else report_mismatch("empty", $sampled(empty), $sampled(mdl_valid == '0));
   a_rvalid: assert property (@(posedge clk) disable iff (!rstn)
      reg_rsp.rvalid == exp_rvalid)
      else report_mismatch("reg_rsp.rvalid", $sampled(reg_rsp.rvalid), $sampled(exp_rvalid));
   a_rdata: assert property (@(posedge clk) disable iff (!rstn)
      !exp_rvalid || reg_rsp.rdata === exp_rdata)
      else report_mismatch("reg_rsp.rdata", $sampled(reg_rsp.rdata), $sampled(exp_rdata));
   a_lvt: assert property (@(posedge clk) disable iff (!rstn)
      stable < 32 || lvt == exp_lvt)
      else report_mismatch("lvt", $sampled(lvt), $sampled(exp_lvt));

   // Back-pressure from the tile and the child manager
   initial begin
      forever begin
         @(negedge clk);
         task_enq_ready = ($urandom % 4) != 0;
         m_resp_ready   = ($urandom % 3) != 0;
      end
   end

   // Stimulus tasks are entered and left on a falling edge
   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic drive_child(input logic tied);
      s_wdata.task_data.ts    = $urandom;
      s_wdata.task_data.hint  = $urandom;
      s_wdata.task_data.fn_id = 4'($urandom);
      s_wdata.task_data.args  = {$urandom, $urandom};
      s_wdata.tied            = tied;
      s_wdata.cq_slot         = 5'($urandom);
      s_wdata.child_id        = 2'($urandom);
      s_wvalid                = 1'b1;
   endtask

   task automatic push_task(input logic tied);
      drive_child(tied);
      do @(posedge clk); while (!s_wready);
      @(negedge clk);
      s_wvalid = 1'b0;
   endtask

   task automatic retry_entry(input int id, input logic abort, input logic tied);
      retry_valid  = 1'b1;
      retry_tsb_id = tsb_pkg::tsb_entry_id_t'(id);
      retry_abort  = abort;
      retry_tied   = tied;
      do @(posedge clk); while (!retry_ready);
      @(negedge clk);
      retry_valid = 1'b0;
   endtask

   task automatic respond(input int id, input logic ack);
      task_resp_valid   = 1'b1;
      task_resp.ack     = ack;
      task_resp.tsb_id  = tsb_pkg::tsb_entry_id_t'(id);
      task_resp.epoch   = 8'($urandom);
      task_resp.tq_slot = 7'($urandom);
      do @(posedge clk); while (!task_resp_ready);
      @(negedge clk);
      task_resp_valid = 1'b0;
   endtask

   task automatic write_tiles(input int n);
      reg_req.wvalid = 1'b1;
      reg_req.waddr  = tsb_pkg::TSB_LOG_N_TILES;
      reg_req.wdata  = n;
      @(negedge clk);
      reg_req.wvalid = 1'b0;
   endtask

   task automatic read_valid_reg();
      reg_req.arvalid = 1'b1;
      reg_req.araddr  = tsb_pkg::TSB_ENTRY_VALID;
      @(negedge clk);
      reg_req.arvalid = 1'b0;
   endtask

   function automatic int pick_valid();
      int ids[$];
      for (int k = 0; k < tsb_pkg::TSB_SIZE; k++) begin
         if (mdl_valid[k]) ids.push_back(k);
      end
      if (ids.size() == 0) return -1;
      return ids[$urandom % ids.size()];
   endfunction

   task automatic random_op();
      int sel;
      int id;
      sel = $urandom % 5;
      id  = pick_valid();
      if (sel == 4) begin
         write_tiles($urandom % 6);
      end else if (id < 0 || (sel < 2 && !mdl_full)) begin
         push_task($urandom % 2);
      end else if (sel == 2) begin
         retry_entry(id, ($urandom % 4) == 0, $urandom % 2);
      end else begin
         respond(id, ($urandom % 4) != 0);
      end
   endtask

   initial begin
      void'($urandom(63029));
      rstn            = 1'b0;
      s_wvalid        = 1'b0;
      s_wdata         = '0;
      retry_valid     = 1'b0;
      retry_tsb_id    = '0;
      retry_abort     = 1'b0;
      retry_tied      = 1'b0;
      task_enq_ready  = 1'b0;
      task_resp_valid = 1'b0;
      task_resp       = '0;
      m_resp_ready    = 1'b0;
      reg_req         = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      idle(40);              // Buffer stays empty while lvt settles to all-ones
      read_valid_reg();
      for (int i = 0; i < tsb_pkg::TSB_SIZE; i++) begin
         if (i == 5) write_tiles(2);
         if (i == 10) write_tiles(7); // Saturates at 4
         push_task($urandom % 2);
      end
      drive_child(1'b1);     // Full, so this one waits while retries go through
      repeat (4) retry_entry($urandom % 16, 1'b0, $urandom % 2);
      s_wvalid = 1'b0;
      idle(40);
      read_valid_reg();
      retry_entry(3, 1'b1, 1'b0);
      retry_entry(9, 1'b1, 1'b0);
      read_valid_reg();
      write_tiles(0);
      push_task(1'b1);       // Refills entry 3 on tile 0
      write_tiles(3);
      idle(40);
      for (int i = 0; i < tsb_pkg::TSB_SIZE; i++) begin
         if (mdl_valid[i]) begin
            respond(i, 1'b0);
            respond(i, 1'b1);
         end
      end
      idle(40);
      read_valid_reg();
      repeat (300) random_op();
      for (int i = 0; i < tsb_pkg::TSB_SIZE; i++) begin
         if (mdl_valid[i]) respond(i, 1'b1);
      end
      idle(40);
      read_valid_reg();
      idle(4);
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      other_errs++;
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: tsb_dest_map.sv
`timescale 1ns/1ps
`default_nettype none

module tsb_dest_map (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire tsb_pkg::tsb_reg_req_t   reg_req,
   input  wire [31:0]                   hint,
   output swarm_task_pkg::tile_id_t     dest_tile
);

   logic [2:0] log_n_tiles; // Held in 0..4

   always_ff @(posedge clk) begin
      if (!rstn) begin
         log_n_tiles <= 3'($clog2(swarm_task_pkg::N_TILES));
      end else if (reg_req.wvalid && reg_req.waddr == tsb_pkg::TSB_LOG_N_TILES) begin
         // Anything above 4 saturates to the full tile range
         if (reg_req.wdata > 32'd4) begin
            log_n_tiles <= 3'd4;
         end else begin
            log_n_tiles <= reg_req.wdata[2:0];
         end
      end
   end

   // Take log_n_tiles hint bits from bit 4 upward
   always_comb begin
      case (log_n_tiles)
         3'd0: dest_tile = 4'd0;
         3'd1: dest_tile = {3'b000, hint[4]};
         3'd2: dest_tile = {2'b00, hint[5:4]};
         3'd3: dest_tile = {1'b0, hint[6:4]};
         default: dest_tile = hint[7:4];
      endcase
   end

endmodule

`default_nettype wire

// File: tsb_entry_table.sv
`timescale 1ns/1ps
`default_nettype none

module tsb_entry_table (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire                                  s_wvalid,
   output logic                                 s_wready,
   input  wire tsb_pkg::tsb_child_req_t         s_wdata,
   input  wire swarm_task_pkg::tile_id_t        dest_tile,
   input  wire                                  retry_valid,
   output logic                                 retry_ready,
   input  wire tsb_pkg::tsb_entry_id_t          retry_tsb_id,
   input  wire                                  retry_abort,
   input  wire                                  retry_tied,
   output logic                                 task_enq_valid,
   input  wire                                  task_enq_ready,
   output tsb_pkg::tsb_enq_t                    task_enq,
   input  wire                                  resp_free,
   input  wire tsb_pkg::tsb_entry_id_t          resp_free_id,
   input  wire tsb_pkg::tsb_entry_id_t          lookup_id,
   output logic                                 lookup_tied,
   output swarm_task_pkg::tile_id_t             lookup_tile,
   output swarm_task_pkg::cq_slice_slot_t       lookup_cq_slot,
   output swarm_task_pkg::child_id_t            lookup_child_id,
   output logic [tsb_pkg::TSB_SIZE-1:0]         entry_valid,
   output swarm_task_pkg::ts_t                  entry_ts [tsb_pkg::TSB_SIZE],
   input  wire tsb_pkg::tsb_reg_req_t           reg_req,
   output tsb_pkg::tsb_reg_rsp_t                reg_rsp,
   output logic                                 s_only_untied,
   output logic                                 empty
);

   swarm_task_pkg::task_t          ent_task     [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::tile_id_t       ent_tile     [tsb_pkg::TSB_SIZE];
   logic                           ent_tied     [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::cq_slice_slot_t ent_cq_slot  [tsb_pkg::TSB_SIZE];
   swarm_task_pkg::child_id_t      ent_child_id [tsb_pkg::TSB_SIZE];

   tsb_pkg::tsb_entry_id_t         free_id;
   logic                           any_free;
   logic                           enq_open;
   logic                           new_take;
   logic                           resend;
   logic                           abort_take;
   logic                           dec_abort;
   logic                           dec_resp;
   logic [tsb_pkg::LOG_TSB_SIZE:0] count;
   logic                           rsp_valid_q;
   logic [31:0]                    rsp_data_q;

   // Lowest free index wins
   always_comb begin
      free_id = '0;
      for (int i = tsb_pkg::TSB_SIZE - 1; i >= 0; i--) begin
         if (!entry_valid[i]) free_id = tsb_pkg::tsb_entry_id_t'(i);
      end
   end

   assign any_free = ~&entry_valid;
   assign enq_open = !task_enq_valid || task_enq_ready; // Output slot empty or draining

   // New tasks have priority over retries
   assign s_wready    = enq_open && any_free;
   assign retry_ready = enq_open && (!s_wvalid || !any_free);

   assign new_take   = s_wvalid && s_wready;
   assign resend     = retry_valid && retry_ready && !retry_abort;
   assign abort_take = retry_valid && retry_ready && retry_abort;

   always_ff @(posedge clk) begin
      if (new_take) begin
         ent_task[free_id]     <= s_wdata.task_data;
         ent_tile[free_id]     <= dest_tile;
         ent_tied[free_id]     <= s_wdata.tied;
         ent_cq_slot[free_id]  <= s_wdata.cq_slot;
         ent_child_id[free_id] <= s_wdata.child_id;
      end else if (resend) begin
         ent_tied[retry_tsb_id] <= retry_tied; // Retry may change tied state
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (new_take || resend) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (new_take) begin
         task_enq <= '{task_data: s_wdata.task_data, tied: s_wdata.tied,
                       dest_tile: dest_tile, tsb_id: free_id};
      end else if (resend) begin
         // Resend the stored copy to the same tile
         task_enq <= '{task_data: ent_task[retry_tsb_id], tied: retry_tied,
                       dest_tile: ent_tile[retry_tsb_id], tsb_id: retry_tsb_id};
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
      end else begin
         if (abort_take) entry_valid[retry_tsb_id] <= 1'b0;
         if (resp_free) entry_valid[resp_free_id] <= 1'b0;
         if (new_take) entry_valid[free_id] <= 1'b1;
      end
   end

   // Count each entry release once, even if abort and ack hit it together
   assign dec_abort = abort_take && entry_valid[retry_tsb_id];
   assign dec_resp  = resp_free && entry_valid[resp_free_id] &&
                      !(abort_take && retry_tsb_id == resp_free_id);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         count <= '0;
      end else begin
         count <= count + {{tsb_pkg::LOG_TSB_SIZE{1'b0}}, new_take}
                        - {{tsb_pkg::LOG_TSB_SIZE{1'b0}}, dec_abort}
                        - {{tsb_pkg::LOG_TSB_SIZE{1'b0}}, dec_resp};
      end
   end

   assign s_only_untied = count > tsb_pkg::ONLY_UNTIED_LIMIT;
   assign empty         = entry_valid == '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= reg_req.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_req.arvalid) begin
         case (reg_req.araddr)
            tsb_pkg::TSB_ENTRY_VALID: rsp_data_q <= 32'(entry_valid);
            default:                  rsp_data_q <= '0;
         endcase
      end
   end

   assign reg_rsp = '{rvalid: rsp_valid_q, rdata: rsp_data_q};

   always_comb begin
      for (int i = 0; i < tsb_pkg::TSB_SIZE; i++) begin
         entry_ts[i] = ent_task[i].ts;
      end
   end

   assign lookup_tied     = ent_tied[lookup_id];
   assign lookup_tile     = ent_tile[lookup_id];
   assign lookup_cq_slot  = ent_cq_slot[lookup_id];
   assign lookup_child_id = ent_child_id[lookup_id];

endmodule

`default_nettype wire

// File: tsb_lvt_scan.sv
`timescale 1ns/1ps
`default_nettype none

module tsb_lvt_scan (
   input  wire                           clk,
   input  wire                           rstn,
   input  wire [tsb_pkg::TSB_SIZE-1:0]   entry_valid,
   input  wire swarm_task_pkg::ts_t      entry_ts [tsb_pkg::TSB_SIZE],
   output swarm_task_pkg::ts_t           lvt
);

   tsb_pkg::tsb_entry_id_t cur;     // Entry visited this cycle
   swarm_task_pkg::ts_t    rolling; // Minimum so far in this pass
   swarm_task_pkg::ts_t    cur_ts;
   logic                   cur_valid;

   assign cur_ts    = entry_ts[cur];
   assign cur_valid = entry_valid[cur];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur <= '0;
      end else begin
         cur <= cur + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rolling <= '0;
         lvt     <= '0;
      end else if (cur == '0) begin
         // Wrap publishes the last pass and restarts from entry 0
         lvt     <= rolling;
         rolling <= cur_valid ? cur_ts : swarm_task_pkg::TS_NONE;
      end else if (cur_valid && cur_ts < rolling) begin
         rolling <= cur_ts;
      end
   end

endmodule

`default_nettype wire

// File: tsb_pkg.sv
`default_nettype none

package tsb_pkg;

   localparam int LOG_TSB_SIZE      = 4;
   localparam int TSB_SIZE          = 2 ** LOG_TSB_SIZE;
   localparam int ONLY_UNTIED_LIMIT = TSB_SIZE - 3;

   typedef logic [LOG_TSB_SIZE-1:0] tsb_entry_id_t;

   // Register port addresses
   typedef enum logic [7:0] {
      TSB_LOG_N_TILES = 8'h00,
      TSB_ENTRY_VALID = 8'h04
   } tsb_reg_addr_e;

   typedef struct packed {
      logic          wvalid;
      tsb_reg_addr_e waddr;
      logic [31:0]   wdata;
      logic          arvalid;
      tsb_reg_addr_e araddr;
   } tsb_reg_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } tsb_reg_rsp_t;

   // New child task from the child manager
   typedef struct packed {
      swarm_task_pkg::task_t          task_data;
      logic                           tied;
      swarm_task_pkg::cq_slice_slot_t cq_slot;
      swarm_task_pkg::child_id_t      child_id;
   } tsb_child_req_t;

   typedef struct packed {
      swarm_task_pkg::task_t    task_data;
      logic                     tied;
      swarm_task_pkg::tile_id_t dest_tile;
      tsb_entry_id_t            tsb_id;
   } tsb_enq_t;

   typedef struct packed {
      logic                     ack;
      tsb_entry_id_t            tsb_id;
      swarm_task_pkg::epoch_t   epoch;
      swarm_task_pkg::tq_slot_t tq_slot;
   } tsb_resp_in_t;

   typedef struct packed {
      logic                           ack;
      tsb_entry_id_t                  tsb_slot;
      swarm_task_pkg::epoch_t         epoch;
      swarm_task_pkg::tq_slot_t       tq_slot;
      swarm_task_pkg::tile_id_t       tile_id;
      swarm_task_pkg::cq_slice_slot_t cq_slot;
      swarm_task_pkg::child_id_t      child_id;
   } tsb_resp_out_t;

endpackage

`default_nettype wire

// File: tsb_resp_return.sv
`timescale 1ns/1ps
`default_nettype none

module tsb_resp_return (
   input  wire                                clk,
   input  wire                                rstn,
   input  wire                                task_resp_valid,
   output logic                               task_resp_ready,
   input  wire tsb_pkg::tsb_resp_in_t         task_resp,
   output tsb_pkg::tsb_entry_id_t             lookup_id,
   input  wire                                lookup_tied,
   input  wire swarm_task_pkg::tile_id_t      lookup_tile,
   input  wire swarm_task_pkg::cq_slice_slot_t lookup_cq_slot,
   input  wire swarm_task_pkg::child_id_t     lookup_child_id,
   output logic                               resp_free,
   output tsb_pkg::tsb_entry_id_t             resp_free_id,
   output logic                               m_resp_valid,
   input  wire                                m_resp_ready,
   output tsb_pkg::tsb_resp_out_t             m_resp
);

   logic resp_take;

   assign task_resp_ready = !m_resp_valid; // One response in flight at most
   assign resp_take       = task_resp_valid && task_resp_ready;
   assign lookup_id       = task_resp.tsb_id;

   // Any ack releases the entry whether tied or not
   assign resp_free    = resp_take && task_resp.ack;
   assign resp_free_id = task_resp.tsb_id;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_take && lookup_tied) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   // Untied responses stop here
   always_ff @(posedge clk) begin
      if (resp_take && lookup_tied) begin
         m_resp <= '{ack:      task_resp.ack,
                     tsb_slot: task_resp.tsb_id,
                     epoch:    task_resp.epoch,
                     tq_slot:  task_resp.tq_slot,
                     tile_id:  lookup_tile,
                     cq_slot:  lookup_cq_slot,
                     child_id: lookup_child_id};
      end
   end

endmodule

`default_nettype wire

// File: tsb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tsb_top (
   input  wire                          clk,
   input  wire                          rstn,
   input  wire                          s_wvalid,
   output logic                         s_wready,
   input  wire tsb_pkg::tsb_child_req_t s_wdata,
   input  wire                          retry_valid,
   output logic                         retry_ready,
   input  wire tsb_pkg::tsb_entry_id_t  retry_tsb_id,
   input  wire                          retry_abort,
   input  wire                          retry_tied,
   output logic                         task_enq_valid,
   input  wire                          task_enq_ready,
   output tsb_pkg::tsb_enq_t            task_enq,
   input  wire                          task_resp_valid,
   output logic                         task_resp_ready,
   input  wire tsb_pkg::tsb_resp_in_t   task_resp,
   output logic                         m_resp_valid,
   input  wire                          m_resp_ready,
   output tsb_pkg::tsb_resp_out_t       m_resp,
   input  wire tsb_pkg::tsb_reg_req_t   reg_req,
   output tsb_pkg::tsb_reg_rsp_t        reg_rsp,
   output logic                         s_only_untied,
   output swarm_task_pkg::ts_t          lvt,
   output logic                         empty
);

   swarm_task_pkg::tile_id_t       dest_tile;
   tsb_pkg::tsb_entry_id_t         lookup_id;
   logic                           lookup_tied;
   swarm_task_pkg::tile_id_t       lookup_tile;
   swarm_task_pkg::cq_slice_slot_t lookup_cq_slot;
   swarm_task_pkg::child_id_t      lookup_child_id;
   logic                           resp_free;
   tsb_pkg::tsb_entry_id_t         resp_free_id;
   logic [tsb_pkg::TSB_SIZE-1:0]   entry_valid;
   swarm_task_pkg::ts_t            entry_ts [tsb_pkg::TSB_SIZE];

   tsb_dest_map dest_map_i (
      .clk       (clk),
      .rstn      (rstn),
      .reg_req   (reg_req),
      .hint      (s_wdata.task_data.hint),
      .dest_tile (dest_tile)
   );

   tsb_entry_table entry_table_i (
      .clk             (clk),
      .rstn            (rstn),
      .s_wvalid        (s_wvalid),
      .s_wready        (s_wready),
      .s_wdata         (s_wdata),
      .dest_tile       (dest_tile),
      .retry_valid     (retry_valid),
      .retry_ready     (retry_ready),
      .retry_tsb_id    (retry_tsb_id),
      .retry_abort     (retry_abort),
      .retry_tied      (retry_tied),
      .task_enq_valid  (task_enq_valid),
      .task_enq_ready  (task_enq_ready),
      .task_enq        (task_enq),
      .resp_free       (resp_free),
      .resp_free_id    (resp_free_id),
      .lookup_id       (lookup_id),
      .lookup_tied     (lookup_tied),
      .lookup_tile     (lookup_tile),
      .lookup_cq_slot  (lookup_cq_slot),
      .lookup_child_id (lookup_child_id),
      .entry_valid     (entry_valid),
      .entry_ts        (entry_ts),
      .reg_req         (reg_req),
      .reg_rsp         (reg_rsp),
      .s_only_untied   (s_only_untied),
      .empty           (empty)
   );

   tsb_resp_return resp_return_i (
      .clk             (clk),
      .rstn            (rstn),
      .task_resp_valid (task_resp_valid),
      .task_resp_ready (task_resp_ready),
      .task_resp       (task_resp),
      .lookup_id       (lookup_id),
      .lookup_tied     (lookup_tied),
      .lookup_tile     (lookup_tile),
      .lookup_cq_slot  (lookup_cq_slot),
      .lookup_child_id (lookup_child_id),
      .resp_free       (resp_free),
      .resp_free_id    (resp_free_id),
      .m_resp_valid    (m_resp_valid),
      .m_resp_ready    (m_resp_ready),
      .m_resp          (m_resp)
   );

   tsb_lvt_scan lvt_scan_i (
      .clk         (clk),
      .rstn        (rstn),
      .entry_valid (entry_valid),
      .entry_ts    (entry_ts),
      .lvt         (lvt)
   );

endmodule

`default_nettype wire
